//--- Makefile
SRCS := $(filter %.sv,$(shell cat vlog.f)) soc_defines.svh

obj_dir/Vtb_dbus_top: $(SRCS) vlog.f
	verilator --binary --assert -Wno-fatal --top-module tb_dbus_top -f vlog.f

run: obj_dir/Vtb_dbus_top
	./obj_dir/Vtb_dbus_top > sim.log 2>&1; cat sim.log
	grep -qx "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

//--- bytes_conv.sv
`timescale 1ns/10ps
`default_nettype none

`include "soc_defines.svh"

module bytes_conv (
    input  wire                        clk,
    input  wire                        rst_n_i,
    input  wire                        ram_req_i,
    input  wire soc_pkg::dbus_addr_u   addr_i,
    input  wire soc_pkg::byte_en_t     be_i,
    input  wire                        we_i,
    input  wire  [`SOC_DATA_W-1:0]     wdata_i,
    input  wire                        tmr_done_i,
    input  wire  [`SOC_DATA_W-1:0]     sram_rdata_i,
    output logic                       tmr_start_o,
    output logic                       sram_en_o,
    output logic                       sram_we_o,
    output logic [`SOC_RAM_IDX_W-1:0]  sram_idx_o,
    output logic [`SOC_DATA_W-1:0]     sram_wdata_o,
    output logic                       ram_done_o,
    output logic [`SOC_DATA_W-1:0]     ram_rdata_o
);

    localparam logic [2:0] IDLE  = 3'd0;
    localparam logic [2:0] READ  = 3'd1;
    localparam logic [2:0] MERGE = 3'd2;
    localparam logic [2:0] WRITE = 3'd3;
    localparam logic [2:0] DONE  = 3'd4;

    logic [2:0]             state_q;
    logic [2:0]             state_d;
    logic [`SOC_DATA_W-1:0] wbuf_q;
    logic [`SOC_DATA_W-1:0] merged;
    logic                   full_word;

    assign full_word = (be_i == '1);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (ram_req_i) begin
                    state_d = (we_i && full_word) ? WRITE : READ;
                end
            end
            READ: begin
                // a partial write goes on to merge once the old word is back.
                if (tmr_done_i) begin
                    state_d = we_i ? MERGE : DONE;
                end
            end
            MERGE:   state_d = WRITE;
            WRITE: begin
                if (tmr_done_i) begin
                    state_d = DONE;
                end
            end
            DONE:    state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        for (int i = 0; i < `SOC_BE_W; i++) begin
            merged[8*i +: 8] = be_i[i] ? wdata_i[8*i +: 8] : sram_rdata_i[8*i +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE && ram_req_i) begin
            wbuf_q <= wdata_i;
        end else if (state_q == MERGE) begin
            wbuf_q <= merged;
        end
    end

    // the SRAM is touched only in the last cycle of each timed access.
    assign tmr_start_o  = (state_q == IDLE && ram_req_i) || (state_q == MERGE);
    assign sram_en_o    = ((state_q == READ) || (state_q == WRITE)) && tmr_done_i;
    assign sram_we_o    = sram_en_o && (state_q == WRITE);
    assign sram_idx_o   = addr_i.ram.idx;
    assign sram_wdata_o = wbuf_q;
    assign ram_done_o   = (state_q == DONE);
    assign ram_rdata_o  = sram_rdata_i;

endmodule

`default_nettype wire

//--- dbus_decoder.sv
`timescale 1ns/10ps
`default_nettype none

`include "soc_defines.svh"

module dbus_decoder (
    input  wire                       clk,
    input  wire                       rst_n_i,
    input  wire                       dbus_valid_i,
    input  wire soc_pkg::dbus_addr_u  dbus_addr_i,
    input  wire                       ram_done_i,
    input  wire  [`SOC_DATA_W-1:0]    ram_rdata_i,
    input  wire                       gpio_done_i,
    input  wire  [`SOC_DATA_W-1:0]    gpio_rdata_i,
    output logic                      ram_req_o,
    output logic                      gpio_req_o,
    output logic                      dbus_ready_o,
    output logic                      dbus_err_o,
    output logic [`SOC_DATA_W-1:0]    dbus_rdata_o
);

    logic busy_q;
    logic err_req_q;
    logic err_ack_q;
    logic accept;
    logic is_ram;
    logic is_gpio;

    assign is_ram  = (dbus_addr_i.ram.tag == `SOC_TAG_RAM);
    assign is_gpio = (dbus_addr_i.gpio.tag == `SOC_TAG_GPIO);
    assign accept  = dbus_valid_i && !busy_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q     <= 1'b0;
            ram_req_o  <= 1'b0;
            gpio_req_o <= 1'b0;
            err_req_q  <= 1'b0;
        end else if (dbus_ready_o) begin
            busy_q     <= 1'b0;
            ram_req_o  <= 1'b0;
            gpio_req_o <= 1'b0;
            err_req_q  <= 1'b0;
        end else if (accept) begin
            busy_q     <= 1'b1;
            ram_req_o  <= is_ram;
            gpio_req_o <= is_gpio;
            err_req_q  <= !is_ram && !is_gpio;
        end
    end

    // an unmapped access answers with the same one cycle delay as GPIO.
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            err_ack_q <= 1'b0;
        end else begin
            err_ack_q <= err_req_q && !err_ack_q;
        end
    end

    assign dbus_ready_o = ram_done_i || gpio_done_i || err_ack_q;
    assign dbus_err_o   = err_ack_q;

    always_comb begin
        if (ram_done_i) begin
            dbus_rdata_o = ram_rdata_i;
        end else if (gpio_done_i) begin
            dbus_rdata_o = gpio_rdata_i;
        end else begin
            dbus_rdata_o = '0;
        end
    end

endmodule

`default_nettype wire

//--- dbus_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "soc_defines.svh"

module dbus_top (
    input  wire                        clk,
    input  wire                        rst_n_i,
    input  wire                        dbus_valid_i,
    input  wire soc_pkg::dbus_addr_u   dbus_addr_i,
    input  wire soc_pkg::byte_en_t     dbus_be_i,
    input  wire                        dbus_we_i,
    input  wire  [`SOC_DATA_W-1:0]     dbus_wdata_i,
    input  wire  [`SOC_GPIO_W-1:0]     gpio_i,
    output wire                        dbus_ready_o,
    output wire                        dbus_err_o,
    output wire  [`SOC_DATA_W-1:0]     dbus_rdata_o,
    output wire  [`SOC_GPIO_W-1:0]     gpio_o
);

    wire                       ram_req;
    wire                       ram_done;
    wire [`SOC_DATA_W-1:0]     ram_rdata;
    wire                       gpio_req;
    wire                       gpio_done;
    wire [`SOC_DATA_W-1:0]     gpio_rdata;
    wire                       tmr_start;
    wire                       tmr_busy;
    wire                       tmr_done;
    wire                       sram_en;
    wire                       sram_we;
    wire [`SOC_RAM_IDX_W-1:0]  sram_idx;
    wire [`SOC_DATA_W-1:0]     sram_wdata;
    wire [`SOC_DATA_W-1:0]     sram_rdata;

    dbus_decoder u_decoder (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .dbus_valid_i (dbus_valid_i),
        .dbus_addr_i  (dbus_addr_i),
        .ram_done_i   (ram_done),
        .ram_rdata_i  (ram_rdata),
        .gpio_done_i  (gpio_done),
        .gpio_rdata_i (gpio_rdata),
        .ram_req_o    (ram_req),
        .gpio_req_o   (gpio_req),
        .dbus_ready_o (dbus_ready_o),
        .dbus_err_o   (dbus_err_o),
        .dbus_rdata_o (dbus_rdata_o)
    );

    bytes_conv u_conv (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .ram_req_i    (ram_req),
        .addr_i       (dbus_addr_i),
        .be_i         (dbus_be_i),
        .we_i         (dbus_we_i),
        .wdata_i      (dbus_wdata_i),
        .tmr_done_i   (tmr_done),
        .sram_rdata_i (sram_rdata),
        .tmr_start_o  (tmr_start),
        .sram_en_o    (sram_en),
        .sram_we_o    (sram_we),
        .sram_idx_o   (sram_idx),
        .sram_wdata_o (sram_wdata),
        .ram_done_o   (ram_done),
        .ram_rdata_o  (ram_rdata)
    );

    ram_wait_timer u_timer (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .start_i (tmr_start),
        .busy_o  (tmr_busy),
        .done_o  (tmr_done)
    );

    sram_array u_sram (
        .clk     (clk),
        .en_i    (sram_en),
        .we_i    (sram_we),
        .idx_i   (sram_idx),
        .wdata_i (sram_wdata),
        .rdata_o (sram_rdata)
    );

    gpio_regs u_gpio (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .req_i   (gpio_req),
        .addr_i  (dbus_addr_i),
        .be_i    (dbus_be_i),
        .we_i    (dbus_we_i),
        .wdata_i (dbus_wdata_i),
        .gpio_i  (gpio_i),
        .done_o  (gpio_done),
        .rdata_o (gpio_rdata),
        .gpio_o  (gpio_o)
    );

endmodule

`default_nettype wire

//--- dbus_top_assert.sv
`timescale 1ns/10ps
`default_nettype none

`include "soc_defines.svh"

module dbus_top_assert (
    input wire                   clk,
    input wire                   rst_n_i,
    input wire                   valid_i,
    input wire                   ready_i,
    input wire                   err_i,
    input wire [`SOC_DATA_W-1:0] rdata_i,
    input wire                   sram_en_i,
    input wire                   tmr_busy_i
);

    ready_needs_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
        ready_i |-> valid_i)
    else $error("ready raised without a valid request");

    // an unmapped access answers with zero read data.
    err_needs_ready: assert property (@(posedge clk) disable iff (!rst_n_i)
        err_i |-> (ready_i && rdata_i == '0))
    else $error("err raised outside a ready cycle or with nonzero read data");

    ready_one_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
        ready_i |=> !ready_i)
    else $error("ready held high for two cycles");

    // the SRAM is only enabled in a timed access that the master still holds.
    sram_en_in_access: assert property (@(posedge clk) disable iff (!rst_n_i)
        sram_en_i |-> (tmr_busy_i && valid_i))
    else $error("sram enabled while the wait timer is idle or no request is pending");

endmodule

bind dbus_top dbus_top_assert u_protocol_assert (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .valid_i    (dbus_valid_i),
    .ready_i    (dbus_ready_o),
    .err_i      (dbus_err_o),
    .rdata_i    (dbus_rdata_o),
    .sram_en_i  (sram_en),
    .tmr_busy_i (tmr_busy)
);

`default_nettype wire

//--- gpio_regs.sv
`timescale 1ns/10ps
`default_nettype none

`include "soc_defines.svh"

module gpio_regs (
    input  wire                        clk,
    input  wire                        rst_n_i,
    input  wire                        req_i,
    input  wire soc_pkg::dbus_addr_u   addr_i,
    input  wire soc_pkg::byte_en_t     be_i,
    input  wire                        we_i,
    input  wire  [`SOC_DATA_W-1:0]     wdata_i,
    input  wire  [`SOC_GPIO_W-1:0]     gpio_i,
    output logic                       done_o,
    output logic [`SOC_DATA_W-1:0]     rdata_o,
    output logic [`SOC_GPIO_W-1:0]     gpio_o
);

    logic [`SOC_GPIO_W-1:0] out_q;
    logic [`SOC_GPIO_W-1:0] in_meta_q;
    logic [`SOC_GPIO_W-1:0] in_sync_q;
    logic                   wr_en;

    // the write happens once, in the first cycle of the request.
    assign wr_en = req_i && !done_o && we_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            done_o <= 1'b0;
        end else begin
            done_o <= req_i && !done_o;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_q <= '0;
        end else if (wr_en) begin
            case (addr_i.gpio.idx)
                2'd0: begin
                    for (int i = 0; i < `SOC_BE_W; i++) begin
                        if (be_i[i]) begin
                            out_q[8*i +: 8] <= wdata_i[8*i +: 8];
                        end
                    end
                end
                2'd2:    out_q <= out_q | wdata_i;
                2'd3:    out_q <= out_q & ~wdata_i;
                default: out_q <= out_q;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            in_meta_q <= '0;
            in_sync_q <= '0;
        end else begin
            in_meta_q <= gpio_i;
            in_sync_q <= in_meta_q;
        end
    end

    assign rdata_o = (addr_i.gpio.idx == 2'd1) ? in_sync_q : out_q;
    assign gpio_o  = out_q;

endmodule

`default_nettype wire

//--- ram_wait_timer.sv
`timescale 1ns/10ps
`default_nettype none

`include "soc_defines.svh"

module ram_wait_timer (
    input  wire  clk,
    input  wire  rst_n_i,
    input  wire  start_i,
    output logic busy_o,
    output logic done_o
);

    logic [`SOC_TMR_W-1:0] count_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else if (busy_o) begin
            count_q <= count_q - 1'b1;
        end else if (start_i) begin
            count_q <= `SOC_TMR_W'(`SOC_RAM_WAIT);
        end
    end

    assign busy_o = (count_q != '0);

    // done marks the final wait cycle, so the access lands as busy drops.
    assign done_o = (count_q == `SOC_TMR_W'(1));

endmodule

`default_nettype wire

//--- soc_defines.svh
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// widths of the data bus words as the processor sees them.
`define SOC_ADDR_W      32
`define SOC_DATA_W      32
`define SOC_BE_W        4

// field widths inside a bus address.
`define SOC_TAG_W       4
`define SOC_OFF_W       2
`define SOC_GPIO_IDX_W  2

// region tags live in the top nibble of the address.
`define SOC_TAG_RAM     4'h0
`define SOC_TAG_GPIO    4'h1

// the SRAM holds 256 words, each access stalls for SOC_RAM_WAIT cycles.
`define SOC_RAM_WORDS   256
`define SOC_RAM_IDX_W   8
`define SOC_RAM_WAIT    2
`define SOC_TMR_W       4

`define SOC_GPIO_W      32

`endif

//--- soc_pkg.sv
`default_nettype none

`include "soc_defines.svh"

package soc_pkg;

    typedef logic [`SOC_BE_W-1:0] byte_en_t;

    // the same address word seen by the SRAM.
    typedef struct packed {
        logic [`SOC_TAG_W-1:0]                                         tag;
        logic [`SOC_ADDR_W-`SOC_TAG_W-`SOC_RAM_IDX_W-`SOC_OFF_W-1:0]   unused;
        logic [`SOC_RAM_IDX_W-1:0]                                     idx;
        logic [`SOC_OFF_W-1:0]                                         off;
    } dbus_ram_addr_t;

    // and seen by the GPIO block.
    typedef struct packed {
        logic [`SOC_TAG_W-1:0]                                         tag;
        logic [`SOC_ADDR_W-`SOC_TAG_W-`SOC_GPIO_IDX_W-`SOC_OFF_W-1:0]  unused;
        logic [`SOC_GPIO_IDX_W-1:0]                                    idx;
        logic [`SOC_OFF_W-1:0]                                         off;
    } dbus_gpio_addr_t;

    typedef union packed {
        dbus_ram_addr_t  ram;
        dbus_gpio_addr_t gpio;
    } dbus_addr_u;

endpackage

`default_nettype wire

//--- sram_array.sv
`timescale 1ns/10ps
`default_nettype none

`include "soc_defines.svh"

module sram_array (
    input  wire                        clk,
    input  wire                        en_i,
    input  wire                        we_i,
    input  wire  [`SOC_RAM_IDX_W-1:0]  idx_i,
    input  wire  [`SOC_DATA_W-1:0]     wdata_i,
    output logic [`SOC_DATA_W-1:0]     rdata_o
);

    logic [`SOC_DATA_W-1:0] mem_q [0:`SOC_RAM_WORDS-1];

    // whole words only, byte merging happens upstream.
    always_ff @(posedge clk) begin
        if (en_i && we_i) begin
            mem_q[idx_i] <= wdata_i;
        end
    end

    // read data holds until the next enabled read.
    always_ff @(posedge clk) begin
        if (en_i && !we_i) begin
            rdata_o <= mem_q[idx_i];
        end
    end

endmodule

`default_nettype wire

//--- tb_dbus_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "soc_defines.svh"

module tb_dbus_top;

    localparam int LAT_SHORT = 2;
    localparam int LAT_RAM   = `SOC_RAM_WAIT + 2;
    localparam int LAT_RMW   = 2 * `SOC_RAM_WAIT + 3;
    localparam int WAIT_MAX  = 20;

    logic                   clk;
    logic                   rst_n_i;
    logic                   dbus_valid_i;
    soc_pkg::dbus_addr_u    dbus_addr_i;
    soc_pkg::byte_en_t      dbus_be_i;
    logic                   dbus_we_i;
    logic [`SOC_DATA_W-1:0] dbus_wdata_i;
    logic [`SOC_GPIO_W-1:0] gpio_i;
    wire                    dbus_ready_o;
    wire                    dbus_err_o;
    wire  [`SOC_DATA_W-1:0] dbus_rdata_o;
    wire  [`SOC_GPIO_W-1:0] gpio_o;

    logic [`SOC_DATA_W-1:0] ram_model [0:`SOC_RAM_WORDS-1];
    logic [`SOC_GPIO_W-1:0] gpio_model;
    logic [`SOC_DATA_W-1:0] exp_rdata;
    logic                   exp_err;
    logic                   chk_read;
    int                     seed;
    int                     mismatches;
    int                     timeouts;

    always #50 clk = ~clk;

    dbus_top dut (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .dbus_valid_i (dbus_valid_i),
        .dbus_addr_i  (dbus_addr_i),
        .dbus_be_i    (dbus_be_i),
        .dbus_we_i    (dbus_we_i),
        .dbus_wdata_i (dbus_wdata_i),
        .gpio_i       (gpio_i),
        .dbus_ready_o (dbus_ready_o),
        .dbus_err_o   (dbus_err_o),
        .dbus_rdata_o (dbus_rdata_o),
        .gpio_o       (gpio_o)
    );

    // read data is only meaningful in the ready cycle of a read.
    rdata_check: assert property (@(posedge clk) disable iff (!rst_n_i)
        (dbus_ready_o && chk_read) |-> (dbus_rdata_o == exp_rdata))
    else begin
        $display("MISMATCH at %0t: read data %h, expected %h",
                 $time, $sampled(dbus_rdata_o), exp_rdata);
        mismatches++;
    end

    err_check: assert property (@(posedge clk) disable iff (!rst_n_i)
        dbus_ready_o |-> (dbus_err_o == exp_err))
    else begin
        $display("MISMATCH at %0t: err flag %b, expected %b", $time, $sampled(dbus_err_o), exp_err);
        mismatches++;
    end

    gpio_check: assert property (@(posedge clk) disable iff (!rst_n_i)
        gpio_o == gpio_model)
    else begin
        $display("MISMATCH at %0t: gpio_o %h, expected %h", $time, $sampled(gpio_o), gpio_model);
        mismatches++;
    end

    reset_check: assert property (@(posedge clk)
        !rst_n_i |-> (!dbus_ready_o && !dbus_err_o && gpio_o == '0))
    else begin
        $display("MISMATCH at %0t: outputs not idle during reset", $time);
        mismatches++;
    end

    function automatic soc_pkg::dbus_addr_u ram_addr(input int idx);
        soc_pkg::dbus_addr_u a;
        a         = '0;
        a.ram.tag = `SOC_TAG_RAM;
        a.ram.idx = idx[`SOC_RAM_IDX_W-1:0];
        return a;
    endfunction

    function automatic soc_pkg::dbus_addr_u gpio_addr(input int sel);
        soc_pkg::dbus_addr_u a;
        a          = '0;
        a.gpio.tag = `SOC_TAG_GPIO;
        a.gpio.idx = sel[1:0];
        return a;
    endfunction

    // tag 7 is not mapped, the low bits still point at a real RAM word.
    function automatic soc_pkg::dbus_addr_u unmapped_addr(input int idx);
        soc_pkg::dbus_addr_u a;
        a         = '0;
        a.ram.tag = 4'h7;
        a.ram.idx = idx[`SOC_RAM_IDX_W-1:0];
        return a;
    endfunction

    // returns on the falling edge where ready is seen, with valid still high.
    task automatic begin_access(input soc_pkg::dbus_addr_u addr, input logic [3:0] be,
                                input logic we, input logic [31:0] wdata, input int bound);
        int cycles;
        cycles       = 0;
        dbus_addr_i  = addr;
        dbus_be_i    = be;
        dbus_we_i    = we;
        dbus_wdata_i = wdata;
        dbus_valid_i = 1'b1;
        do begin
            @(negedge clk);
            cycles++;
        end while (!dbus_ready_o && cycles < WAIT_MAX);
        if (!dbus_ready_o) begin
            $display("timeout at %0t: no ready for address %h", $time, addr);
            timeouts++;
        end else begin
            lat_check: assert (cycles <= bound) else begin
                $display("MISMATCH at %0t: latency %0d cycles, bound %0d", $time, cycles, bound);
                mismatches++;
            end
        end
    endtask

    task automatic end_access();
        @(negedge clk);
        dbus_valid_i = 1'b0;
        chk_read     = 1'b0;
        exp_err      = 1'b0;
    endtask

    task automatic ram_write(input int idx, input logic [3:0] be, input logic [31:0] data);
        int bound;
        bound = (be == 4'hF) ? LAT_RAM : LAT_RMW;
        begin_access(ram_addr(idx), be, 1'b1, data, bound);
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                ram_model[idx][8*b +: 8] = data[8*b +: 8];
            end
        end
        end_access();
    endtask

    task automatic ram_read(input int idx);
        exp_rdata = ram_model[idx];
        chk_read  = 1'b1;
        begin_access(ram_addr(idx), 4'hF, 1'b0, '0, LAT_RAM);
        end_access();
    endtask

    task automatic gpio_write(input int sel, input logic [3:0] be, input logic [31:0] data);
        begin_access(gpio_addr(sel), be, 1'b1, data, LAT_SHORT);
        case (sel)
            0: begin
                for (int b = 0; b < 4; b++) begin
                    if (be[b]) begin
                        gpio_model[8*b +: 8] = data[8*b +: 8];
                    end
                end
            end
            2:       gpio_model = gpio_model | data;
            3:       gpio_model = gpio_model & ~data;
            default: gpio_model = gpio_model;
        endcase
        end_access();
    endtask

    task automatic gpio_read(input int sel, input logic [31:0] expected);
        exp_rdata = expected;
        chk_read  = 1'b1;
        begin_access(gpio_addr(sel), 4'hF, 1'b0, '0, LAT_SHORT);
        end_access();
    endtask

    task automatic unmapped_access(input int idx, input logic we, input logic [31:0] data);
        exp_rdata = '0;
        exp_err   = 1'b1;
        chk_read  = 1'b1;
        begin_access(unmapped_addr(idx), 4'hF, we, data, LAT_SHORT);
        end_access();
    endtask

    initial begin
        logic [31:0] rnd;
        int          idx;
        seed         = 63;
        mismatches   = 0;
        timeouts     = 0;
        clk          = 1'b0;
        rst_n_i      = 1'b0;
        dbus_valid_i = 1'b0;
        dbus_addr_i  = '0;
        dbus_be_i    = '0;
        dbus_we_i    = 1'b0;
        dbus_wdata_i = '0;
        gpio_i       = '0;
        gpio_model   = '0;
        exp_rdata    = '0;
        exp_err      = 1'b0;
        chk_read     = 1'b0;
        repeat (3) @(negedge clk);
        rst_n_i = 1'b1;
        repeat (2) @(negedge clk);

        for (int i = 0; i < `SOC_RAM_WORDS; i++) begin
            ram_write(i, 4'hF, $random(seed));
        end
        for (int i = 0; i < `SOC_RAM_WORDS; i++) begin
            ram_read(i);
        end

        // partial writes go through the read-modify-write path.
        for (int n = 0; n < 64; n++) begin
            rnd = $random(seed);
            idx = int'(rnd[7:0]);
            ram_write(idx, rnd[11:8], $random(seed));
            ram_read(idx);
        end

        gpio_write(0, 4'b0101, 32'hA5C3_5A3C);
        gpio_read(0, gpio_model);
        for (int n = 0; n < 8; n++) begin
            gpio_write(2, 4'hF, $random(seed));
            gpio_read(2, gpio_model);
            gpio_write(3, 4'hF, $random(seed));
            gpio_read(3, gpio_model);
            gpio_write(0, 4'($random(seed)), $random(seed));
        end
        gpio_i = $random(seed);
        repeat (3) @(negedge clk);
        gpio_read(1, gpio_i);
        gpio_write(1, 4'hF, 32'hFFFF_FFFF);
        gpio_read(0, gpio_model);

        // word 4 seen through the GPIO view is the output register.
        unmapped_access(4, 1'b1, 32'hDEAD_BEEF);
        unmapped_access(4, 1'b0, '0);
        ram_read(4);
        gpio_read(0, gpio_model);

        repeat (2) @(negedge clk);
        $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+.
soc_pkg.sv
dbus_decoder.sv
bytes_conv.sv
ram_wait_timer.sv
sram_array.sv
gpio_regs.sv
dbus_top.sv
dbus_top_assert.sv
tb_dbus_top.sv
